/* all.f */
+incdir+logic
logic/ieuPkg.sv
logic/hazardIf.sv
logic/instrDecoder.sv
logic/controller.sv
logic/hazardUnit.sv
logic/ieuCtrl.sv
sim/clockGen.sv
sim/ieuCtrlTb.sv

/* sim/ieuCtrlTb.sv */
`default_nettype none
`include "ieu_config.svh"

module ieuCtrlTb;

  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opAmo    = 7'b0101111;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opReg32  = 7'b0111011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opSystem = 7'b1110011;
  localparam logic [31:0] nop     = 32'h00000013;  // addi x0, x0, 0

  logic                clk;
  logic                arstN;
  logic [31:0]         instrD;
  logic                illegalIeuD;
  logic [2:0]          flagsE;       // {zero, lt, ltu}
  logic                memBusy;
  logic                stallF;
  ieuPkg::immSrcT      immSrcD;
  logic                illegalBaseD;
  logic [4:0]          aluControlE;
  logic                aluSrcAE;
  logic                aluSrcBE;
  logic                targetSrcE;
  logic [2:0]          funct3E;
  logic                mulDivE;
  logic                w64E;
  logic                pcSrcE;
  logic [1:0]          memRWM;
  logic [2:0]          funct3M;
  logic [1:0]          atomicM;
  logic                csrReadM;
  logic                csrWriteM;
  logic                privilegedM;
  logic                regWriteW;
  ieuPkg::resultSrcT   resultSrcW;
  logic [4:0]          rdW;
  logic                instrValidW;
  logic                csrWritePending;
  logic [31:0]         lfsrState;

  clockGen clkGen (.clk(clk), .arstN(arstN));

  ieuCtrl dut (.*);

  ////////////////////
  // helpers
  ////////////////////

  // raw field packing, immediates ride in the same slots
  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [4:0] randBits(input int n);
    logic [4:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[3:0], lfsrBit()};
    return r;
  endfunction

  function automatic logic [4:0] randReg();
    logic [4:0] r;
    r = randBits(5);
    if (r == 5'd0) r = 5'd1;  // keep x0 out
    return r;
  endfunction

  // branch table, flags {zero, lt, ltu}
  function automatic logic expectTaken(input logic [2:0] f3, input logic [2:0] flags);
    case (f3)
      3'b000:  return flags[2];
      3'b001:  return !flags[2];
      3'b100:  return flags[1];
      3'b101:  return !flags[1];
      3'b110:  return flags[0];
      3'b111:  return !flags[0];
      default: return 1'b0;
    endcase
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    abortRun($sformatf("CHECK FAILED at time %0t: %s got %0h expected %0h",
                       $time, what, got, exp));
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkReg(input logic [4:0] got, input logic [4:0] exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkMemRW(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkAtomic(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkFunct3(input logic [2:0] got, input logic [2:0] exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkAlu(input logic [4:0] got, input logic [4:0] exp, input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkImm(input ieuPkg::immSrcT got, input ieuPkg::immSrcT exp,
                          input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic checkResultSrc(input ieuPkg::resultSrcT got, input ieuPkg::resultSrcT exp,
                                input string what);
    if (got !== exp) mismatch(what, got, exp);
  endtask

  task automatic tick();  // lands 1 after the edge, where inputs change
    @(posedge clk);
    #1;
  endtask

  task automatic settle();  // sample point, clear of edge and drive
    #1;
  endtask

  task automatic drain();
    instrD  = nop;
    flagsE  = 3'b000;
    memBusy = 1'b0;
    repeat (4) tick();
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic testReset();
    int waited;
    waited = 0;
    while (arstN !== 1'b1) begin
      @(posedge clk);
      waited++;
      if (waited > 20) abortRun("timeout: reset was never released");
    end
    #1;
    settle();
    checkBit(regWriteW, 1'b0, "regWriteW after reset");
    checkBit(instrValidW, 1'b0, "instrValidW after reset");
    checkMemRW(memRWM, 2'b00, "memRWM after reset");
    checkBit(csrWriteM, 1'b0, "csrWriteM after reset");
    checkBit(pcSrcE, 1'b0, "pcSrcE after reset");
    checkBit(stallF, 1'b0, "stallF after reset");
  endtask

  // decode now, alu control and E fields once it sits in E
  // expE is {aluSrcA, aluSrcB, targetSrc, w64, mulDiv}
  task automatic decodeCase(input logic [31:0] instr, input logic hasImm,
                            input ieuPkg::immSrcT expImm, input logic [4:0] expAlu,
                            input logic [4:0] expE, input string name);
    instrD = instr;
    settle();
    if (hasImm) checkImm(immSrcD, expImm, {name, " immSrcD"});
    checkBit(illegalBaseD, 1'b0, {name, " illegalBaseD"});
    tick();
    checkAlu(aluControlE, expAlu, {name, " aluControlE"});
    checkBit(aluSrcAE, expE[4], {name, " aluSrcAE"});
    checkBit(aluSrcBE, expE[3], {name, " aluSrcBE"});
    checkBit(targetSrcE, expE[2], {name, " targetSrcE"});
    checkBit(w64E, expE[1], {name, " w64E"});
    checkBit(mulDivE, expE[0], {name, " mulDivE"});
    checkFunct3(funct3E, instr[14:12], {name, " funct3E"});
  endtask

  task automatic testDecode();
    // unused opcode flagged, never writes back
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, 5'd7, 7'b1111111);
    settle();
    checkBit(illegalBaseD, 1'b1, "illegal opcode illegalBaseD");
    tick();
    instrD = nop;
    repeat (2) tick();
    settle();
    checkReg(rdW, 5'd7, "illegal slot rdW");
    checkBit(instrValidW, 1'b1, "illegal slot instrValidW");
    checkBit(regWriteW, 1'b0, "illegal slot regWriteW");
    tick();
    // rd x3, rs1 x1, rs2 x2 so no load-use pair shows up
    decodeCase(enc(7'h0, 5'd0, 5'd1, 3'b010, 5'd3, opLoad), 1, ieuPkg::I, 5'b00000,
               5'b01000, "lw");
    decodeCase(enc(7'h0, 5'd2, 5'd1, 3'b010, 5'd0, opStore), 1, ieuPkg::S, 5'b00000,
               5'b01000, "sw");
    decodeCase(enc(7'h0, 5'd0, 5'd1, 3'b010, 5'd3, opImm), 1, ieuPkg::I, 5'b01010,
               5'b01000, "slti");
    decodeCase(enc(7'h0, 5'd0, 5'd1, 3'b100, 5'd3, opImm), 1, ieuPkg::I, 5'b00100,
               5'b01000, "xori");
    decodeCase(enc(7'h20, 5'd1, 5'd1, 3'b101, 5'd3, opImm), 1, ieuPkg::I, 5'b01101,
               5'b01000, "srai");
    decodeCase(enc(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opReg), 0, ieuPkg::I, 5'b01000,
               5'b00000, "sub");
    decodeCase(enc(7'h0, 5'd2, 5'd1, 3'b011, 5'd3, opReg), 0, ieuPkg::I, 5'b01011,
               5'b00000, "sltu");
    decodeCase(enc(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, opReg), 0, ieuPkg::I, 5'b00000,
               5'b00001, "mul");
    if (`XLEN == 64) begin
      decodeCase(enc(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opReg32), 0, ieuPkg::I, 5'b11000,
                 5'b00010, "subw");
    end
    decodeCase(enc(7'h12, 5'd0, 5'd0, 3'b000, 5'd3, opLui), 1, ieuPkg::U, 5'b01110,
               5'b01000, "lui");
    decodeCase(enc(7'h0, 5'd0, 5'd0, 3'b000, 5'd3, opAuipc), 1, ieuPkg::U, 5'b00000,
               5'b11000, "auipc");
    decodeCase(enc(7'h0, 5'd2, 5'd1, 3'b000, 5'd0, opBranch), 1, ieuPkg::B, 5'b01000,
               5'b00000, "beq");
    decodeCase(enc(7'h0, 5'd0, 5'd1, 3'b000, 5'd3, opJalr), 1, ieuPkg::I, 5'b00000,
               5'b00100, "jalr");
    drain();
  endtask

  task automatic testTravel();
    logic [4:0] rdA;
    logic [4:0] rdB;
    logic [4:0] rdC;
    rdA = randReg();
    rdB = randReg();
    rdC = randReg();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b011, rdA, opLoad);  // ld rdA, 0(x0)
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, rdB, opReg);   // add rdB, x0, x0
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b110, rdC, opImm);   // ori rdC, x0, 0
    settle();
    checkMemRW(memRWM, 2'b10, "load memRWM");
    checkFunct3(funct3M, 3'b011, "load funct3M");
    tick();
    instrD = nop;
    settle();
    checkBit(regWriteW, 1'b1, "load regWriteW");
    checkResultSrc(resultSrcW, ieuPkg::mem, "load resultSrcW");
    checkReg(rdW, rdA, "load rdW");
    checkBit(instrValidW, 1'b1, "load instrValidW");
    tick();
    settle();
    checkReg(rdW, rdB, "add rdW");
    checkResultSrc(resultSrcW, ieuPkg::alu, "add resultSrcW");
    tick();
    settle();
    checkReg(rdW, rdC, "ori rdW");
    drain();
    // amoadd.w then ecall, watched in M
    instrD = enc(7'h00, 5'd2, 5'd1, 3'b010, rdA, opAmo);
    settle();
    checkImm(immSrcD, ieuPkg::atomicZero, "amo immSrcD");
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, 5'd0, opSystem);  // ecall
    tick();
    instrD = nop;
    settle();
    checkMemRW(memRWM, 2'b11, "amo memRWM");
    checkAtomic(atomicM, 2'b10, "amo atomicM");
    checkFunct3(funct3M, 3'b010, "amo funct3M");
    checkBit(privilegedM, 1'b0, "amo privilegedM");
    tick();
    settle();
    checkBit(privilegedM, 1'b1, "ecall privilegedM");
    checkAtomic(atomicM, 2'b00, "ecall atomicM");
    drain();
  endtask

  task automatic testBranches();
    logic [4:0] r;
    logic [4:0] rdMark;
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        repeat (2) begin
          instrD = enc(7'h0, 5'd2, 5'd1, 3'(f), 5'd0, opBranch);
          tick();
          instrD = nop;
          r = randBits(3);
          flagsE = r[2:0];
          settle();
          checkBit(pcSrcE, expectTaken(3'(f), r[2:0]), $sformatf("branch f3 %0d pcSrcE", f));
          tick();
          flagsE = 3'b000;
        end
      end
    end
    // jal, the slot behind it must die
    rdMark = randReg();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, 5'd0, opJal);
    settle();
    checkImm(immSrcD, ieuPkg::J, "jal immSrcD");
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, rdMark, opImm);
    r = randBits(3);
    flagsE = r[2:0];
    settle();
    checkBit(pcSrcE, 1'b1, "jal pcSrcE");
    repeat (5) begin
      tick();
      instrD = nop;
      settle();
      checkBit(instrValidW && rdW == rdMark, 1'b0, "wrong-path slot at W");
    end
    drain();
  endtask

  task automatic testLoadUse();
    logic [4:0] rdL;
    logic [4:0] rdU;
    int stallCycles;
    rdL = randReg();
    rdU = randReg();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b010, rdL, opLoad);
    tick();
    instrD = enc(7'h0, 5'd0, rdL, 3'b000, rdU, opReg);  // add rdU, rdL, x0
    settle();
    checkBit(stallF, 1'b1, "load-use stallF");
    stallCycles = 0;
    while (stallF) begin  // fetch holds instrD meanwhile
      tick();
      settle();
      stallCycles++;
      if (stallCycles > 8) abortRun("timeout: stallF stuck high after load-use");
    end
    checkBit(stallCycles == 1, 1'b1, "load-use stall lasts one cycle");
    tick();
    instrD = nop;
    settle();
    checkReg(rdW, rdL, "load rdW ahead of bubble");
    tick();
    settle();
    checkBit(instrValidW, 1'b0, "bubble instrValidW");
    tick();
    settle();
    checkReg(rdW, rdU, "dependent rdW");
    checkBit(instrValidW, 1'b1, "dependent instrValidW");
    drain();
    // load to x0 never stalls
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b010, 5'd0, opLoad);
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, rdU, opReg);
    settle();
    checkBit(stallF, 1'b0, "x0 load stallF");
    drain();
  endtask

  task automatic testMemStallCsr();
    logic [4:0] rdA;
    logic [4:0] rdB;
    rdA = randReg();
    rdB = randReg();
    if (rdB == rdA) rdB = ~rdA;
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, rdA, opImm);
    tick();
    instrD = enc(7'h0, 5'd0, 5'd0, 3'b000, rdB, opImm);
    tick();
    instrD = nop;
    tick();
    memBusy = 1'b1;  // rdA sits in W
    settle();
    checkBit(stallF, 1'b1, "memBusy stallF");
    repeat (4) begin
      tick();
      settle();
      checkReg(rdW, rdA, "frozen rdW");
      checkBit(regWriteW, 1'b1, "frozen regWriteW");
    end
    tick();
    memBusy = 1'b0;
    settle();
    checkReg(rdW, rdA, "rdW at release");
    tick();
    settle();
    checkReg(rdW, rdB, "rdW after release");
    drain();
    // csrrs rd, mscratch, x0 reads only
    instrD = enc(7'h1a, 5'd0, 5'd0, 3'b010, rdA, opSystem);
    settle();
    checkBit(csrWritePending, 1'b0, "csrrs x0 pending in D");
    tick();
    instrD = nop;
    tick();
    settle();
    checkBit(csrReadM, 1'b1, "csrrs x0 csrReadM");
    checkBit(csrWriteM, 1'b0, "csrrs x0 csrWriteM");
    tick();
    // csrrw rd, mscratch, x5
    instrD = enc(7'h1a, 5'd0, 5'd5, 3'b001, rdA, opSystem);
    settle();
    checkBit(csrWritePending, 1'b1, "csrrw pending in D");
    tick();
    instrD = nop;
    settle();
    checkBit(csrWritePending, 1'b1, "csrrw pending in E");
    tick();
    settle();
    checkBit(csrWritePending, 1'b1, "csrrw pending in M");
    checkBit(csrWriteM, 1'b1, "csrrw csrWriteM");
    tick();
    settle();
    checkBit(csrWritePending, 1'b0, "csrrw pending after M");
    drain();
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    lfsrState   = 32'h5338;
    instrD      = nop;
    illegalIeuD = 1'b0;
    flagsE      = 3'b000;
    memBusy     = 1'b0;
    testReset();
    testDecode();
    testTravel();
    testBranches();
    testLoadUse();
    testMemStallCsr();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/clockGen.sv */
`default_nettype none

module clockGen (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // period 10
  end

  // reset held over three rising edges, released off the edge
  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    #2 arstN = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/ieuCtrl.sv */
`default_nettype none

module ieuCtrl (
  input  logic              clk,
  input  logic              arstN,
  input  logic [31:0]       instrD,
  input  logic              illegalIeuD,
  input  logic [2:0]        flagsE,      // {zero, lt, ltu}
  input  logic              memBusy,
  output logic              stallF,
  output ieuPkg::immSrcT    immSrcD,
  output logic              illegalBaseD,
  output logic [4:0]        aluControlE,
  output logic              aluSrcAE,
  output logic              aluSrcBE,
  output logic              targetSrcE,
  output logic [2:0]        funct3E,
  output logic              mulDivE,
  output logic              w64E,
  output logic              pcSrcE,
  output logic [1:0]        memRWM,
  output logic [2:0]        funct3M,
  output logic [1:0]        atomicM,
  output logic              csrReadM,
  output logic              csrWriteM,
  output logic              privilegedM,
  output logic              regWriteW,
  output ieuPkg::resultSrcT resultSrcW,
  output logic [4:0]        rdW,
  output logic              instrValidW,
  output logic              csrWritePending
);

  hazardIf hzBus ();

  controller ctrl (
    .clk             (clk),
    .arstN           (arstN),
    .instrD          (instrD),
    .illegalIeuD     (illegalIeuD),
    .flagsE          (flagsE),
    .hz              (hzBus.controller),
    .immSrcD         (immSrcD),
    .illegalBaseD    (illegalBaseD),
    .aluControlE     (aluControlE),
    .aluSrcAE        (aluSrcAE),
    .aluSrcBE        (aluSrcBE),
    .targetSrcE      (targetSrcE),
    .funct3E         (funct3E),
    .mulDivE         (mulDivE),
    .w64E            (w64E),
    .pcSrcE          (pcSrcE),
    .memRWM          (memRWM),
    .funct3M         (funct3M),
    .atomicM         (atomicM),
    .csrReadM        (csrReadM),
    .csrWriteM       (csrWriteM),
    .privilegedM     (privilegedM),
    .regWriteW       (regWriteW),
    .resultSrcW      (resultSrcW),
    .rdW             (rdW),
    .instrValidW     (instrValidW),
    .csrWritePending (csrWritePending)
  );

  hazardUnit hzUnit (
    .memBusy (memBusy),
    .hz      (hzBus.hazard),
    .stallF  (stallF)
  );

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`default_nettype none

module hazardUnit (
  input  logic    memBusy,  // lsu not done
  hazardIf.hazard hz,
  output logic    stallF
);

  logic loadUse;

  // load in E writing a reg that D reads, x0 never counts
  assign loadUse = hz.memReadE & (hz.rdE != 5'd0)
                 & ((hz.rdE == hz.rs1D) | (hz.rdE == hz.rs2D));

  ////////////////////
  // fixed priority
  ////////////////////

  always_comb begin
    stallF    = 1'b0;
    hz.stallD = 1'b0;
    hz.stallE = 1'b0;
    hz.stallM = 1'b0;
    hz.stallW = 1'b0;
    hz.flushD = 1'b0;
    hz.flushE = 1'b0;
    hz.flushM = 1'b0;  // idle flush only, not raised here
    hz.flushW = 1'b0;
    if (memBusy) begin
      stallF    = 1'b1;  // freeze whole pipe
      hz.stallD = 1'b1;
      hz.stallE = 1'b1;
      hz.stallM = 1'b1;
      hz.stallW = 1'b1;
    end else if (loadUse) begin
      stallF    = 1'b1;  // hold F and D one cycle
      hz.stallD = 1'b1;
      hz.flushE = 1'b1;  // bubble into E
    end else if (hz.pcSrcE) begin
      hz.flushD = 1'b1;  // kill wrong path
      hz.flushE = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/controller.sv */
`default_nettype none

module controller (
  input  logic              clk,
  input  logic              arstN,
  input  logic [31:0]       instrD,
  input  logic              illegalIeuD,
  input  logic [2:0]        flagsE,        // {zero, lt, ltu}
  hazardIf.controller       hz,
  // decode
  output ieuPkg::immSrcT    immSrcD,
  output logic              illegalBaseD,
  // execute
  output logic [4:0]        aluControlE,
  output logic              aluSrcAE,
  output logic              aluSrcBE,
  output logic              targetSrcE,
  output logic [2:0]        funct3E,
  output logic              mulDivE,
  output logic              w64E,
  output logic              pcSrcE,
  // memory
  output logic [1:0]        memRWM,
  output logic [2:0]        funct3M,
  output logic [1:0]        atomicM,
  output logic              csrReadM,
  output logic              csrWriteM,
  output logic              privilegedM,
  // writeback
  output logic              regWriteW,
  output ieuPkg::resultSrcT resultSrcW,
  output logic [4:0]        rdW,
  output logic              instrValidW,
  output logic              csrWritePending
);

  ieuPkg::decodeCtrlT ctrlD;
  ieuPkg::execCtrlT   nextE;
  ieuPkg::execCtrlT   ctrlE;
  ieuPkg::memCtrlT    ctrlM;
  ieuPkg::wbCtrlT     ctrlW;
  logic               instrValidD;
  logic               zeroE;
  logic               ltE;
  logic               ltuE;
  logic               branchTakenE;

  ////////////////////
  // decode
  ////////////////////

  instrDecoder dec (
    .instrD      (instrD),
    .illegalIeuD (illegalIeuD),
    .ctrlD       (ctrlD)
  );

  assign immSrcD      = ctrlD.immSrc;
  assign illegalBaseD = ctrlD.illegal;
  assign hz.rs1D      = instrD[19:15];
  assign hz.rs2D      = instrD[24:20];

  // D slot valid, dropped when fetch is flushed
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrValidD <= 1'b0;
    end else if (hz.flushD) begin
      instrValidD <= 1'b0;
    end else if (!hz.stallD) begin
      instrValidD <= 1'b1;
    end
  end

  assign nextE = '{
    regWrite:   ctrlD.regWrite,
    aluSrcA:    ctrlD.aluSrcA,
    aluSrcB:    ctrlD.aluSrcB,
    memRW:      ctrlD.memRW,
    resultSrc:  ctrlD.resultSrc,
    branch:     ctrlD.branch,
    jump:       ctrlD.jump,
    targetSrc:  ctrlD.targetSrc,
    w64:        ctrlD.w64,
    csrRead:    ctrlD.csrRead,
    csrWrite:   ctrlD.csrWrite,
    privileged: ctrlD.privileged,
    mulDiv:     ctrlD.mulDiv,
    atomic:     ctrlD.atomic,
    aluControl: ctrlD.aluControl,
    funct3:     instrD[14:12],
    rd:         instrD[11:7],
    instrValid: instrValidD
  };

  ////////////////////
  // execute
  ////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE <= '0;
    end else if (hz.flushE) begin
      ctrlE <= '0;                // bubble
    end else if (!hz.stallE) begin
      ctrlE <= nextE;
    end
  end

  assign {zeroE, ltE, ltuE} = flagsE;

  always_comb begin
    case (ctrlE.funct3)
      3'b000:  branchTakenE = zeroE;   // beq
      3'b001:  branchTakenE = ~zeroE;  // bne
      3'b100:  branchTakenE = ltE;     // blt
      3'b101:  branchTakenE = ~ltE;    // bge
      3'b110:  branchTakenE = ltuE;    // bltu
      3'b111:  branchTakenE = ~ltuE;   // bgeu
      default: branchTakenE = 1'b0;
    endcase
  end

  assign pcSrcE      = ctrlE.jump | (ctrlE.branch & branchTakenE);
  assign hz.pcSrcE   = pcSrcE;
  assign hz.rdE      = ctrlE.rd;
  assign hz.memReadE = ctrlE.memRW[1];  // loads, lr, amo

  assign aluControlE = ctrlE.aluControl;
  assign aluSrcAE    = ctrlE.aluSrcA;
  assign aluSrcBE    = ctrlE.aluSrcB;
  assign targetSrcE  = ctrlE.targetSrc;
  assign funct3E     = ctrlE.funct3;
  assign mulDivE     = ctrlE.mulDiv;
  assign w64E        = ctrlE.w64;

  ////////////////////
  // memory, writeback
  ////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlM <= '0;
    end else if (hz.flushM) begin
      ctrlM <= '0;
    end else if (!hz.stallM) begin
      ctrlM <= '{ctrlE.regWrite, ctrlE.resultSrc, ctrlE.memRW, ctrlE.csrRead,
                 ctrlE.csrWrite, ctrlE.privileged, ctrlE.funct3, ctrlE.atomic,
                 ctrlE.rd, ctrlE.instrValid};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlW <= '0;
    end else if (hz.flushW) begin
      ctrlW <= '0;
    end else if (!hz.stallW) begin
      ctrlW <= '{ctrlM.regWrite, ctrlM.resultSrc, ctrlM.rd, ctrlM.instrValid};
    end
  end

  assign memRWM      = ctrlM.memRW;
  assign funct3M     = ctrlM.funct3;
  assign atomicM     = ctrlM.atomic;
  assign csrReadM    = ctrlM.csrRead;
  assign csrWriteM   = ctrlM.csrWrite;
  assign privilegedM = ctrlM.privileged;

  assign regWriteW   = ctrlW.regWrite;
  assign resultSrcW  = ctrlW.resultSrc;
  assign rdW         = ctrlW.rd;
  assign instrValidW = ctrlW.instrValid;

  // any csr write still ahead of writeback
  assign csrWritePending = ctrlD.csrWrite | ctrlE.csrWrite | ctrlM.csrWrite;

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none
`include "ieu_config.svh"

module instrDecoder (
  input  logic [31:0]        instrD,
  input  logic               illegalIeuD,  // fault raised outside the base decode
  output ieuPkg::decodeCtrlT ctrlD
);

  logic [6:0]         op;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [1:0]         aluOp;       // 00 add, 01 sub, 10 funct decode, 11 pass b
  logic               altOp;
  logic [4:0]         aluControl;
  logic               csrZeroSrc;
  ieuPkg::decodeCtrlT raw;         // word before alu and csr fixups

  assign op     = instrD[6:0];
  assign funct3 = instrD[14:12];
  assign funct7 = instrD[31:25];

  ////////////////////
  // main decoder
  ////////////////////

  always_comb begin
    raw   = '0;            // everything off, immSrc I
    aluOp = 2'b00;
    case (op)
      7'b0000011: begin    // loads
        raw.regWrite  = 1'b1;
        raw.aluSrcB   = 1'b1;
        raw.memRW     = 2'b10;
        raw.resultSrc = ieuPkg::mem;
      end
      7'b0001111: begin    // fence, nop in order
      end
      7'b0010011: begin    // op-imm
        raw.regWrite = 1'b1;
        raw.aluSrcB  = 1'b1;
        aluOp        = 2'b10;
      end
      7'b0010111: begin    // auipc
        raw.regWrite = 1'b1;
        raw.immSrc   = ieuPkg::U;
        raw.aluSrcA  = 1'b1;
        raw.aluSrcB  = 1'b1;
      end
      7'b0011011: begin    // op-imm-32
        if (`XLEN == 64) begin
          raw.regWrite = 1'b1;
          raw.aluSrcB  = 1'b1;
          raw.w64      = 1'b1;
          aluOp        = 2'b10;
        end else begin
          raw.illegal = 1'b1;
        end
      end
      7'b0100011: begin    // stores
        raw.immSrc  = ieuPkg::S;
        raw.aluSrcB = 1'b1;
        raw.memRW   = 2'b01;
      end
      7'b0101111: begin    // amo space
        if (`A_SUPPORTED != 0) begin
          raw.regWrite = 1'b1;
          raw.immSrc   = ieuPkg::atomicZero;
          raw.aluSrcB  = 1'b1;
          case (instrD[31:27])
            5'b00010: begin  // lr
              raw.memRW     = 2'b10;
              raw.resultSrc = ieuPkg::mem;
              raw.atomic    = 2'b01;
            end
            5'b00011: begin  // sc, writes back the flag
              raw.memRW     = 2'b01;
              raw.resultSrc = ieuPkg::scFlag;
              raw.atomic    = 2'b01;
            end
            default: begin   // read-modify-write amo
              raw.memRW     = 2'b11;
              raw.resultSrc = ieuPkg::mem;
              raw.atomic    = 2'b10;
            end
          endcase
        end else begin
          raw.illegal = 1'b1;
        end
      end
      7'b0110011, 7'b0111011: begin  // op and op-32
        if (op[3] && `XLEN != 64) begin
          raw.illegal = 1'b1;          // no W ops on rv32
        end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
          raw.regWrite = 1'b1;
          raw.w64      = op[3];
          aluOp        = 2'b10;
        end else if (funct7 == 7'b0000001 && `M_SUPPORTED != 0) begin
          raw.regWrite  = 1'b1;
          raw.resultSrc = ieuPkg::mulDiv;
          raw.mulDiv    = 1'b1;
          raw.w64       = op[3];
        end else begin
          raw.illegal = 1'b1;
        end
      end
      7'b0110111: begin    // lui
        raw.regWrite = 1'b1;
        raw.immSrc   = ieuPkg::U;
        raw.aluSrcB  = 1'b1;
        aluOp        = 2'b11;
      end
      7'b1100011: begin    // branches compare via sub
        raw.immSrc = ieuPkg::B;
        raw.branch = 1'b1;
        aluOp      = 2'b01;
      end
      7'b1100111: begin    // jalr, I imm
        raw.regWrite  = 1'b1;
        raw.jump      = 1'b1;
        raw.targetSrc = 1'b1;
      end
      7'b1101111: begin    // jal
        raw.regWrite = 1'b1;
        raw.immSrc   = ieuPkg::J;
        raw.jump     = 1'b1;
      end
      7'b1110011: begin    // system
        if (funct3 == 3'b000) begin
          raw.privileged = 1'b1;  // ecall, mret etc. decoded downstream
        end else begin
          raw.regWrite  = 1'b1;
          raw.resultSrc = ieuPkg::csr;
          raw.csrRead   = 1'b1;
        end
      end
      default: raw.illegal = 1'b1;
    endcase
  end

  ////////////////////
  // alu control
  ////////////////////

  // alternate encodings: sub (reg form only), sra, slt, sltu
  assign altOp = (funct3 == 3'b000 & funct7[5] & op[5])
               | (funct3 == 3'b101 & funct7[5])
               | (funct3 == 3'b010)
               | (funct3 == 3'b011);

  always_comb begin
    case (aluOp)
      2'b00:   aluControl = 5'b00000;                 // add, addresses
      2'b01:   aluControl = 5'b01000;                 // sub
      2'b11:   aluControl = 5'b01110;                 // pass b
      default: aluControl = {raw.w64, altOp, funct3};
    endcase
  end

  // csrrs/csrrc with x0 or zero uimm only read
  assign csrZeroSrc = (instrD[19:15] == 5'd0);

  always_comb begin
    ctrlD            = raw;
    ctrlD.aluControl = aluControl;
    ctrlD.csrWrite   = raw.csrRead & ~(csrZeroSrc & funct3[1]);
    if (illegalIeuD) begin
      ctrlD         = '0;           // squash, keep only the fault
      ctrlD.illegal = raw.illegal;
    end
  end

endmodule

`default_nettype wire

/* logic/hazardIf.sv */
`default_nettype none

// controller <-> hazard unit, plain levels
interface hazardIf;

  // from the controller
  logic [4:0] rs1D;
  logic [4:0] rs2D;
  logic [4:0] rdE;
  logic       memReadE;   // load sitting in E
  logic       pcSrcE;     // redirect

  // from the hazard unit
  logic stallD;
  logic stallE;
  logic stallM;
  logic stallW;
  logic flushD;
  logic flushE;
  logic flushM;
  logic flushW;

  modport controller (
    output rs1D, rs2D, rdE, memReadE, pcSrcE,
    input  stallD, stallE, stallM, stallW,
    input  flushD, flushE, flushM, flushW
  );

  modport hazard (
    input  rs1D, rs2D, rdE, memReadE, pcSrcE,
    output stallD, stallE, stallM, stallW,
    output flushD, flushE, flushM, flushW
  );

endinterface

`default_nettype wire

/* logic/ieuPkg.sv */
`default_nettype none

package ieuPkg;

  ////////////////////
  // enums
  ////////////////////

  // writeback source select
  typedef enum logic [2:0] {
    alu    = 3'd0,
    mem    = 3'd1,
    csr    = 3'd2,
    mulDiv = 3'd3,
    scFlag = 3'd4   // sc success flag
  } resultSrcT;

  // immediate format
  typedef enum logic [2:0] {
    I          = 3'd0,
    S          = 3'd1,
    B          = 3'd2,
    J          = 3'd3,
    U          = 3'd4,
    atomicZero = 3'd5  // atomics take a zero offset
  } immSrcT;

  ////////////////////
  // control words
  ////////////////////

  // full decode stage word
  typedef struct packed {
    logic       regWrite;
    immSrcT     immSrc;
    logic       aluSrcA;     // 1 selects pc
    logic       aluSrcB;     // 1 selects immediate
    logic [1:0] memRW;       // 10 read, 01 write, 11 amo
    resultSrcT  resultSrc;
    logic       branch;
    logic       jump;
    logic       targetSrc;   // jalr target from rs1
    logic       w64;         // 32-bit op on rv64
    logic       csrRead;
    logic       csrWrite;
    logic       privileged;
    logic       mulDiv;
    logic [1:0] atomic;      // 01 lr/sc, 10 amo
    logic [4:0] aluControl;
    logic       illegal;
  } decodeCtrlT;

  // execute stage, no immSrc or illegal
  typedef struct packed {
    logic       regWrite;
    logic       aluSrcA;
    logic       aluSrcB;
    logic [1:0] memRW;
    resultSrcT  resultSrc;
    logic       branch;
    logic       jump;
    logic       targetSrc;
    logic       w64;
    logic       csrRead;
    logic       csrWrite;
    logic       privileged;
    logic       mulDiv;
    logic [1:0] atomic;
    logic [4:0] aluControl;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic       instrValid;
  } execCtrlT;

  // memory stage
  typedef struct packed {
    logic       regWrite;
    resultSrcT  resultSrc;
    logic [1:0] memRW;
    logic       csrRead;
    logic       csrWrite;
    logic       privileged;
    logic [2:0] funct3;      // access size for the lsu
    logic [1:0] atomic;
    logic [4:0] rd;
    logic       instrValid;
  } memCtrlT;

  // writeback stage
  typedef struct packed {
    logic       regWrite;
    resultSrcT  resultSrc;
    logic [4:0] rd;
    logic       instrValid;
  } wbCtrlT;

endpackage

`default_nettype wire

/* logic/ieu_config.svh */
`ifndef IEU_CONFIG_SVH
`define IEU_CONFIG_SVH

////////////////////
// core width
////////////////////

// integer register width, 32 or 64
// 64 turns on the W-type opcodes
`define XLEN 64

////////////////////
// extensions
////////////////////

`define M_SUPPORTED 1  // mul/div decode
`define A_SUPPORTED 1  // lr, sc and amo decode

`endif
